// ==== build.f ====
design/audio_pkg.sv
design/audio_dac.sv
design/sample_ram.sv
design/audio_mixer.sv
design/audio_top.sv
testbench/tb_audio.sv

// ==== Bender.yml ====
package:
  name: audio_channel

sources:
  - files:
      - design/audio_pkg.sv
      - design/audio_dac.sv
      - design/sample_ram.sv
      - design/audio_mixer.sv
      - design/audio_top.sv
  - target: test
    files:
      - testbench/tb_audio.sv

// ==== testbench/tb_audio.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_audio
    import audio_pkg::*;
();

    logic            clk;
    logic            reset_i;
    audio_chan_cfg_t cfg;
    logic            restart_i;
    logic            ram_wr_i;
    addr_t           ram_wr_addr_i;
    word_t           ram_wr_data_i;
    logic            reload_o;
    logic            pdm_l_o;
    logic            pdm_r_o;

    logic [31:0] rng;
    word_t       model_mem [16];   // copy of the random words in memory

    audio_top UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .cfg_i         (cfg),
        .restart_i     (restart_i),
        .ram_wr_i      (ram_wr_i),
        .ram_wr_addr_i (ram_wr_addr_i),
        .ram_wr_data_i (ram_wr_data_i),
        .reload_o      (reload_o),
        .pdm_l_o       (pdm_l_o),
        .pdm_r_o       (pdm_r_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // signed sample times volume, >>> 6, clamp, then offset by 128
    function automatic int expected_dac(input logic [7:0] sample, input int vol);
        int s;
        int scaled;
        s = (sample >= 8'h80) ? int'(sample) - 256 : int'(sample);
        scaled = (s * vol) >>> 6;
        if (scaled > 127) begin
            scaled = 127;
        end else if (scaled < -128) begin
            scaled = -128;
        end
        return scaled + 128;
    endfunction

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic wait_reload(input int limit, output int cycles);
        int  n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            n++;
            seen = (reload_o === 1'b1);
        end
        assert (seen) else begin
            $display("timeout: no reload pulse within %0d cycles", limit);
            stop_run();
        end
        cycles = n;
    endtask

    // one 256-cycle density window on both outputs
    task automatic count_ones(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (256) begin
            @(negedge clk);
            ones_l += int'(pdm_l_o);
            ones_r += int'(pdm_r_o);
            check_value("reload_o", int'(reload_o) & int'(!cfg.enable), 0);
        end
    endtask

    task automatic set_channel(input logic en, input int vl, input int vr,
                               input int p, input int len);
        @(negedge clk);
        cfg.enable = en;
        cfg.vol_l  = 7'(vl);
        cfg.vol_r  = 7'(vr);
        cfg.period = 15'(p);
        cfg.start  = '0;
        cfg.length = 15'(len);
    endtask

    // write constant or random words from address 0 with the channel off
    task automatic fill_words(input int count, input logic random, input word_t w);
        @(negedge clk);
        cfg.enable = 1'b0;
        for (int a = 0; a < count; a++) begin
            if (random) begin
                rng = xorshift(rng);
                w = rng[15:0];
                if (w[15:8] == w[7:0]) begin
                    w[7:0] = ~w[7:0];   // keep the two bytes apart
                end
                model_mem[a] = w;
            end
            @(negedge clk);
            ram_wr_i      = 1'b1;
            ram_wr_addr_i = addr_t'(a);
            ram_wr_data_i = w;
        end
        @(negedge clk);
        ram_wr_i = 1'b0;
    endtask

    // both outputs at mid-scale after reset and after disable
    task automatic check_silence();
        int ones_l;
        int ones_r;
        repeat (8) @(negedge clk);
        count_ones(ones_l, ones_r);
        check_value("pdm_l_o ones", ones_l, 128);
        check_value("pdm_r_o ones", ones_r, 128);
    endtask

    task automatic volume_case(input logic [7:0] sample, input int vl, input int vr);
        int c;
        int ones_l;
        int ones_r;
        fill_words(4, 1'b0, {sample, sample});
        set_channel(1'b1, vl, vr, 400, 3);
        wait_reload(8, c);
        repeat (400 + 2 + 8) @(negedge clk);   // first sample after enable is silent
        count_ones(ones_l, ones_r);
        check_value("pdm_l_o ones", ones_l, expected_dac(sample, vl));
        check_value("pdm_r_o ones", ones_r, expected_dac(sample, vr));
    endtask

    task automatic reload_interval(input int p, input int len, input int loops);
        int c;
        wait_reload(8, c);                      // wrap right after enable
        repeat (loops) begin
            wait_reload(2 * (len + 1) * (p + 2) + 4, c);
            check_value("reload_o interval", c, 2 * (len + 1) * (p + 2));
        end
    endtask

    task automatic test_restart();
        int p;
        int len;
        int c;
        rng = xorshift(rng);
        p = 2 + int'(rng[3:0]);
        len = 1 + int'(rng[6:4]);
        set_channel(1'b1, 32, 32, p, len);
        reload_interval(p, len, 1);
        repeat ((p + 2) + (p + 2) / 2 - 1) @(negedge clk);   // between two sample ticks
        @(negedge clk);
        restart_i = 1'b1;
        @(negedge clk);
        restart_i = 1'b0;
        wait_reload(p + 3, c);
        wait_reload(2 * (len + 1) * (p + 2) + 4, c);
        check_value("reload_o interval", c, 2 * (len + 1) * (p + 2));
    endtask

    // high byte then low byte of words 0 and 1
    task automatic test_sample_order();
        int    vl;
        int    vr;
        int    c;
        int    ones_l;
        int    ones_r;
        byte_t b;
        rng = xorshift(rng);
        vl = 32 + int'(rng[4:0]);
        vr = 64 + int'(rng[10:5]);
        set_channel(1'b1, vl, vr, 300, 1);
        wait_reload(8, c);
        repeat (302 + 8) @(negedge clk);
        for (int m = 1; m <= 4; m++) begin
            b = (m % 2 == 1) ? model_mem[(m - 1) / 2][15:8] : model_mem[(m - 1) / 2][7:0];
            count_ones(ones_l, ones_r);
            check_value("pdm_l_o ones", ones_l, expected_dac(b, vl));
            check_value("pdm_r_o ones", ones_r, expected_dac(b, vr));
            repeat (302 - 256) @(negedge clk);
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        cfg           = '0;
        restart_i     = 1'b0;
        ram_wr_i      = 1'b0;
        ram_wr_addr_i = '0;
        ram_wr_data_i = '0;
        rng           = 32'd21;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;

        check_silence();
        volume_case(8'h40, 7'h20, 7'h20);
        volume_case(8'h7F, 7'h7F, 7'h7F);
        volume_case(8'h80, 7'h7F, 7'h7F);
        volume_case(8'h40, 7'h00, 7'h40);

        fill_words(16, 1'b1, '0);
        repeat (4) begin
            rng = xorshift(rng);
            set_channel(1'b0, 0, 0, 0, 0);
            set_channel(1'b1, 16, 16, 2 + int'(rng[3:0]), int'(rng[6:4]));
            reload_interval(int'(cfg.period), int'(cfg.length), 3);
        end
        set_channel(1'b0, 0, 0, 0, 0);
        test_restart();
        set_channel(1'b0, 0, 0, 0, 0);
        test_sample_order();
        @(negedge clk);
        cfg.enable = 1'b0;   // disable during playback
        check_silence();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/audio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// single stereo audio channel with its own sample memory
module audio_top
    import audio_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire audio_chan_cfg_t cfg_i,
    input  wire logic            restart_i,
    input  wire logic            ram_wr_i,
    input  wire addr_t           ram_wr_addr_i,
    input  wire word_t           ram_wr_data_i,
    output logic                 reload_o,
    output logic                 pdm_l_o,
    output logic                 pdm_r_o
);

    logic  fetch;        // DMA request level
    addr_t fetch_addr;
    logic  fetch_ack;    // one-cycle pulse from the RAM
    word_t fetch_word;

    audio_mixer mixer (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_i        (cfg_i),
        .restart_i    (restart_i),
        .reload_o     (reload_o),
        .fetch_o      (fetch),
        .fetch_addr_o (fetch_addr),
        .ack_i        (fetch_ack),
        .word_i       (fetch_word),
        .pdm_l_o      (pdm_l_o),
        .pdm_r_o      (pdm_r_o)
    );

    sample_ram ram (
        .clk          (clk),
        .reset_i      (reset_i),
        .wr_i         (ram_wr_i),
        .wr_addr_i    (ram_wr_addr_i),
        .wr_data_i    (ram_wr_data_i),
        .fetch_i      (fetch),
        .fetch_addr_i (fetch_addr),
        .ack_o        (fetch_ack),
        .data_o       (fetch_word)
    );

endmodule

`default_nettype wire

// ==== design/audio_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_mixer
    import audio_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire audio_chan_cfg_t cfg_i,
    input  wire logic            restart_i,
    output logic                 reload_o,
    output logic                 fetch_o,
    output addr_t                fetch_addr_o,
    input  wire logic            ack_i,
    input  wire word_t           word_i,
    output logic                 pdm_l_o,
    output logic                 pdm_r_o
);

    fetch_state_t fetch_state;
    mix_state_t   mix_state;

    logic [15:0]       period_cnt;   // bit 15 is the underflow flag
    logic [15:0]       length_cnt;   // words left, bit 15 is the underflow flag
    logic [15:0]       length_nxt;
    addr_t             chan_addr;
    word_t             chan_buff;    // DMA word, next sample in the high byte
    logic [1:0]        buff_ok;      // valid mask for the two buffer bytes
    logic              chan_2nd;     // next boundary plays the second byte
    logic              chan_fetch;   // word wanted from memory
    logic signed [7:0] chan_val;     // current sample

    logic sample_tick;
    logic ack_take;
    logic force_wrap;

    logic signed [7:0]  mix_val;
    logic signed [7:0]  mix_vol_l;
    logic signed [7:0]  mix_vol_r;
    logic signed [15:0] prod_l;
    logic signed [15:0] prod_r;
    byte_t              dac_l_val;
    byte_t              dac_r_val;

    // scale back, clamp to the signed byte range, then offset to unsigned
    function automatic byte_t to_dac(input logic signed [15:0] prod);
        logic signed [15:0] scaled;
        logic signed [7:0]  clamped;
        scaled = prod >>> MIX_SHIFT;
        if (scaled > SAT_MAX) begin
            clamped = 8'sd127;
        end else if (scaled < SAT_MIN) begin
            clamped = -8'sd128;
        end else begin
            clamped = scaled[7:0];
        end
        return {~clamped[7], clamped[6:0]};
    endfunction

    assign length_nxt  = length_cnt - 1'b1;
    assign sample_tick = period_cnt[15] && cfg_i.enable;
    assign ack_take    = (fetch_state == FETCH_READ) && ack_i;
    assign force_wrap  = restart_i || !cfg_i.enable;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_cnt   <= '1;
            length_cnt   <= '1;     // first enabled boundary wraps
            chan_addr    <= '0;
            buff_ok      <= 2'b00;
            chan_2nd     <= 1'b1;
            chan_fetch   <= 1'b0;
            chan_val     <= '0;
            reload_o     <= 1'b0;
            fetch_state  <= FETCH_SETUP;
            fetch_o      <= 1'b0;
            fetch_addr_o <= '0;
        end else begin
            reload_o   <= 1'b0;
            period_cnt <= period_cnt - 1'b1;

            if (sample_tick) begin
                period_cnt <= {1'b0, cfg_i.period};
                chan_2nd   <= !chan_2nd;
                chan_val   <= buff_ok[1] ? signed'(chan_buff[15:8]) : 8'sd0;  // silence if stale
                buff_ok    <= {buff_ok[0], 1'b0};

                // word used up, line up the next one
                if (chan_2nd) begin
                    chan_fetch <= 1'b1;
                    if (length_nxt[15]) begin
                        chan_addr  <= cfg_i.start;
                        length_cnt <= {1'b0, cfg_i.length};
                        reload_o   <= 1'b1;
                    end else begin
                        chan_addr  <= chan_addr + 1'b1;
                        length_cnt <= length_nxt;
                    end
                end
            end

            case (fetch_state)
                FETCH_SETUP: begin
                    if (chan_fetch) begin
                        fetch_o      <= 1'b1;
                        fetch_addr_o <= chan_addr;
                        fetch_state  <= FETCH_READ;
                    end
                end
                FETCH_READ: begin
                    if (ack_take) begin
                        fetch_o     <= 1'b0;   // request held until ack
                        chan_fetch  <= 1'b0;
                        buff_ok     <= 2'b11;
                        fetch_state <= FETCH_SETUP;
                    end
                end
            endcase

            // wrap at the next boundary and drop any fetch in flight
            if (force_wrap) begin
                period_cnt  <= '1;
                length_cnt  <= '1;
                buff_ok     <= 2'b00;
                chan_2nd    <= 1'b1;
                chan_fetch  <= 1'b0;
                fetch_o     <= 1'b0;
                fetch_state <= FETCH_SETUP;
            end

            if (!cfg_i.enable) begin
                chan_val <= '0;
            end
        end
    end

    // sample buffer, loaded on ack and shifted one byte per sample
    always_ff @(posedge clk) begin
        if (ack_take) begin
            chan_buff <= word_i;
        end else if (sample_tick) begin
            chan_buff <= {chan_buff[7:0], 8'h00};
        end
    end

    // multiplier operands, sample and zero-extended volumes
    always_ff @(posedge clk) begin
        if (mix_state == MIX_MULT) begin
            mix_val   <= chan_val;
            mix_vol_l <= signed'({1'b0, cfg_i.vol_l});
            mix_vol_r <= signed'({1'b0, cfg_i.vol_r});
        end
    end

    assign prod_l = mix_val * mix_vol_l;
    assign prod_r = mix_val * mix_vol_r;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_state <= MIX_MULT;
            dac_l_val <= DAC_SILENCE;
            dac_r_val <= DAC_SILENCE;
        end else begin
            case (mix_state)
                MIX_MULT: begin
                    mix_state <= MIX_OUT;
                end
                MIX_OUT: begin
                    dac_l_val <= to_dac(prod_l);
                    dac_r_val <= to_dac(prod_r);
                    mix_state <= MIX_MULT;
                end
            endcase
        end
    end

    audio_dac dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (dac_l_val),
        .pulse_o (pdm_l_o)
    );

    audio_dac dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (dac_r_val),
        .pulse_o (pdm_r_o)
    );

endmodule

`default_nettype wire

// ==== design/sample_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// word-wide sample memory
// host write port and a DMA read port that acks one cycle after the request
module sample_ram
    import audio_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire logic  wr_i,
    input  wire addr_t wr_addr_i,
    input  wire word_t wr_data_i,
    input  wire logic  fetch_i,
    input  wire addr_t fetch_addr_i,
    output logic       ack_o,
    output word_t      data_o
);

    word_t mem [RAM_DEPTH];

    // separate write and read ports, a host write never holds off a fetch
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_addr_i[RAM_AW-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_i) begin
            data_o <= mem[fetch_addr_i[RAM_AW-1:0]];   // upper address bits ignored
        end
    end

    // one ack per request
    // the requester still holds fetch in the cycle after ack
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= fetch_i && !ack_o;
        end
    end

endmodule

`default_nettype wire

// ==== design/audio_dac.sv ====
`timescale 1ns/1ps
`default_nettype none

// first-order delta-sigma modulator
// the carry out of an 8-bit accumulator gives value/256 density
module audio_dac
    import audio_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire byte_t value_i,
    output logic       pulse_o
);

    byte_t      acc;
    logic [8:0] sum;

    assign sum = {1'b0, acc} + {1'b0, value_i};   // bit 8 is the carry

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc     <= sum[7:0];
            pulse_o <= sum[8];    // registered pulse stream
        end
    end

endmodule

`default_nettype wire

// ==== design/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // sample memory geometry
    localparam int ADDR_W    = 16;
    localparam int RAM_DEPTH = 1024;               // words actually implemented
    localparam int RAM_AW    = $clog2(RAM_DEPTH);  // low address bits used by the RAM

    // channel setting widths
    localparam int VOL_W    = 7;
    localparam int PERIOD_W = 15;
    localparam int LEN_W    = 15;

    // mix stage scaling
    localparam int MIX_SHIFT = 6;     // product >>> 6 back to sample range
    localparam int SAT_MAX   = 127;
    localparam int SAT_MIN   = -128;

    localparam logic [7:0] DAC_SILENCE = 8'h80;   // unsigned mid-scale

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [15:0]       word_t;     // two signed 8-bit samples with the high byte first
    typedef logic [7:0]        byte_t;     // unsigned DAC value

    // host-held channel settings in 61 bits
    typedef struct packed {
        logic                enable;
        logic [VOL_W-1:0]    vol_l;
        logic [VOL_W-1:0]    vol_r;
        logic [PERIOD_W-1:0] period;   // sample every period+2 clocks
        addr_t               start;    // first word of the sample
        logic [LEN_W-1:0]    length;   // length+1 words per loop
    } audio_chan_cfg_t;

    // DMA fetch sequencing
    typedef enum logic {
        FETCH_SETUP,
        FETCH_READ
    } fetch_state_t;

    // volume multiply then output
    typedef enum logic {
        MIX_MULT,
        MIX_OUT
    } mix_state_t;

endpackage

`default_nettype wire
